// File: rtl/mem_bus_pkg.sv
package mem_bus_pkg;

  // bus geometry
  localparam int unsigned ADDR_WIDTH = 32; // word address
  localparam int unsigned DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // internal startup ram covers 0 .. INT_MEM_WORDS-1
  localparam int unsigned INT_MEM_WORDS = 200;
  localparam int unsigned INT_ADDR_WIDTH = $clog2(INT_MEM_WORDS); // ram index bits

  // external sram covers INT_MEM_WORDS .. EXT_MEM_END-1
  localparam int unsigned EXT_MEM_END = 524288;
  localparam int unsigned SRAM_ADDR_WIDTH = 19;

  typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t; // bus addr minus INT_MEM_WORDS

  // which region an access lands in
  typedef enum logic [1:0] {
    REGION_INT,
    REGION_EXT,
    REGION_NONE // unmapped, answered in the return stage
  } region_t;

  // external controller sequence, encodings as on the old bus
  typedef enum logic [2:0] {
    WAIT              = 3'd0,
    READ_SET_ADDRESS  = 3'd1,
    READ_DATA_GET     = 3'd2,
    READ_FINISH       = 3'd3,
    WRITE_SET_ADDRESS = 3'd4,
    WRITE_SET_WE      = 3'd5,
    WRITE_FINISH      = 3'd6
  } sram_state_t;

  // startup image for the internal ram
  localparam string MEM_INIT_FILE = "mem.hex";

endpackage

// File: rtl/region_decode.sv
`timescale 1ns/100ps

module region_decode (
  input  logic               clk,
  input  logic               reset,
  input  logic               read_q,
  input  logic               write_q,
  input  mem_bus_pkg::addr_t addr,
  input  mem_bus_pkg::data_t wdata,
  input  logic               busy_clear,
  output mem_bus_pkg::addr_t req_addr,
  output mem_bus_pkg::data_t req_wdata,
  output logic               req_write,
  output logic               int_start,
  output logic               ext_start,
  output logic               none_start
);
  import mem_bus_pkg::*;

  logic    busy;       // one access in flight
  logic    launch;     // request taken last edge
  logic    req_take;
  region_t region_sel; // classification of the live address
  region_t region_q;

  // sample only while idle
  assign req_take = !busy && (read_q || write_q);

  // address map check, done here only
  always_comb begin
    if (addr < addr_t'(INT_MEM_WORDS)) begin
      region_sel = REGION_INT;
    end else if (addr < addr_t'(EXT_MEM_END)) begin
      region_sel = REGION_EXT;
    end else begin
      region_sel = REGION_NONE; // above the sram window
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      launch   <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      launch <= req_take;
      if (req_take) begin
        busy     <= 1'b1;
        region_q <= region_sel;
      end else if (busy_clear) begin
        busy <= 1'b0; // return stage saw done
      end
    end
  end

  // request payload, held for the whole access
  always_ff @(posedge clk) begin
    if (req_take) begin
      req_addr  <= addr;
      req_wdata <= wdata;
      req_write <= write_q;
    end
  end

  // one start strobe, one edge after the sample
  always_ff @(posedge clk) begin
    if (reset) begin
      int_start  <= 1'b0;
      ext_start  <= 1'b0;
      none_start <= 1'b0;
    end else begin
      int_start  <= launch && (region_q == REGION_INT);
      ext_start  <= launch && (region_q == REGION_EXT);
      none_start <= launch && (region_q == REGION_NONE);
    end
  end

endmodule

// File: rtl/startup_ram.sv
`timescale 1ns/100ps

module startup_ram (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               req_write,
  input  mem_bus_pkg::addr_t req_addr,
  input  mem_bus_pkg::data_t req_wdata,
  output logic               done,
  output mem_bus_pkg::data_t rdata
);
  import mem_bus_pkg::*;

  data_t                     mem [INT_MEM_WORDS]; // word ram
  data_t                     rd_q;                // read result
  logic [INT_ADDR_WIDTH-1:0] word_idx;

  // decoder already checked the range so low bits are enough
  assign word_idx = req_addr[INT_ADDR_WIDTH-1:0];

  initial begin
    for (int i = 0; i < INT_MEM_WORDS; i++) begin
      mem[i] = '0; // words past the image read zero
    end
    $readmemh(MEM_INIT_FILE, mem);
  end

  // array port writes or reads on start
  always_ff @(posedge clk) begin
    if (start) begin
      if (req_write) begin
        mem[word_idx] <= req_wdata;
      end else begin
        rd_q <= mem[word_idx];
      end
    end
  end

  // answer one edge after start
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // silent on the or-merge unless answering
  assign rdata = done ? rd_q : '0;

endmodule

// File: rtl/sram_ctrl.sv
`timescale 1ns/100ps

module sram_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    req_write,
  input  mem_bus_pkg::addr_t      req_addr,
  input  mem_bus_pkg::data_t      req_wdata,
  output logic                    done,
  output mem_bus_pkg::data_t      rdata,
  output mem_bus_pkg::sram_addr_t prg_addr,
  output logic                    prg_ce,   // active low
  output logic                    prg_oe,   // active low
  output logic                    prg_we,   // active low
  inout  wire mem_bus_pkg::data_t prg_data
);
  import mem_bus_pkg::*;

  sram_state_t state;
  sram_state_t state_next;
  addr_t       ext_offset; // bus address relative to the sram base
  data_t       wdata_q;
  data_t       rdata_q;
  logic        drive_q;    // we own prg_data

  assign ext_offset = req_addr - addr_t'(INT_MEM_WORDS);

  // six-state read/write sequence
  always_comb begin
    state_next = state;
    case (state)
      WAIT: begin
        if (start) begin
          state_next = req_write ? WRITE_SET_ADDRESS : READ_SET_ADDRESS;
        end
      end
      READ_SET_ADDRESS:  state_next = READ_DATA_GET;
      READ_DATA_GET:     state_next = READ_FINISH;  // data sampled leaving here
      READ_FINISH:       state_next = WAIT;
      WRITE_SET_ADDRESS: state_next = WRITE_SET_WE;
      WRITE_SET_WE:      state_next = WRITE_FINISH;
      WRITE_FINISH:      state_next = WAIT;         // we back high, data still held
      default:           state_next = WAIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= WAIT;
    end else begin
      state <= state_next;
    end
  end

  // pins registered from the next state so they line up with state
  always_ff @(posedge clk) begin
    if (reset) begin
      prg_ce  <= 1'b1;
      prg_oe  <= 1'b1;
      prg_we  <= 1'b1;
      drive_q <= 1'b0;
    end else begin
      prg_ce  <= (state_next == WAIT);
      prg_oe  <= !(state_next inside {READ_SET_ADDRESS, READ_DATA_GET, READ_FINISH});
      prg_we  <= (state_next != WRITE_SET_WE); // single low cycle
      drive_q <= state_next inside {WRITE_SET_ADDRESS, WRITE_SET_WE, WRITE_FINISH};
    end
  end

  // address and write data captured with the start
  always_ff @(posedge clk) begin
    if ((state == WAIT) && start) begin
      prg_addr <= ext_offset[SRAM_ADDR_WIDTH-1:0];
      wdata_q  <= req_wdata;
    end
  end

  // read capture in data-get
  always_ff @(posedge clk) begin
    if (state == READ_DATA_GET) begin
      rdata_q <= prg_data;
    end
  end

  assign prg_data = drive_q ? wdata_q : 'z; // released outside writes

  assign done  = (state == READ_FINISH) || (state == WRITE_FINISH);
  assign rdata = (state == READ_FINISH) ? rdata_q : '0; // zero unless answering a read

endmodule

// File: rtl/bus_return.sv
`timescale 1ns/100ps

module bus_return (
  input  logic               clk,
  input  logic               reset,
  input  logic               int_done,
  input  mem_bus_pkg::data_t int_rdata,
  input  logic               ext_done,
  input  mem_bus_pkg::data_t ext_rdata,
  input  logic               none_start,
  input  logic               req_write,
  output logic               read_dn,
  output logic               write_dn,
  output mem_bus_pkg::data_t rdata,
  output logic               busy_clear
);
  import mem_bus_pkg::*;

  logic  none_done; // unmapped answer, one edge after its start
  logic  any_done;
  data_t any_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      none_done <= 1'b0;
    end else begin
      none_done <= none_start;
    end
  end

  // or-merge, idle regions drive zero
  assign any_done  = int_done | ext_done | none_done;
  assign any_rdata = int_rdata | ext_rdata; // unmapped adds nothing

  always_ff @(posedge clk) begin
    if (reset) begin
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      rdata    <= '0;
    end else begin
      read_dn  <= any_done && !req_write;
      write_dn <= any_done && req_write;
      if (any_done && !req_write) begin
        rdata <= any_rdata; // held until the next read
      end
    end
  end

  // frees the decoder alongside the done strobe
  assign busy_clear = read_dn | write_dn;

endmodule

// File: rtl/mem_bus_top.sv
`timescale 1ns/100ps

module mem_bus_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    read_q,
  input  logic                    write_q,
  input  mem_bus_pkg::addr_t      addr,
  input  mem_bus_pkg::data_t      wdata,
  output logic                    read_dn,
  output logic                    write_dn,
  output mem_bus_pkg::data_t      rdata,
  output mem_bus_pkg::sram_addr_t prg_addr,
  output logic                    prg_ce,
  output logic                    prg_oe,
  output logic                    prg_we,
  inout  wire mem_bus_pkg::data_t prg_data
);
  import mem_bus_pkg::*;

  // latched request, shared by all regions
  addr_t req_addr;
  data_t req_wdata;
  logic  req_write;

  logic  int_start;
  logic  ext_start;
  logic  none_start;

  // region answers into the merge
  logic  int_done;
  data_t int_rdata;
  logic  ext_done;
  data_t ext_rdata;

  logic  busy_clear;

  region_decode u_decode (
    .clk        (clk),
    .reset      (reset),
    .read_q     (read_q),
    .write_q    (write_q),
    .addr       (addr),
    .wdata      (wdata),
    .busy_clear (busy_clear),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_write  (req_write),
    .int_start  (int_start),
    .ext_start  (ext_start),
    .none_start (none_start)
  );

  startup_ram u_int_ram (
    .clk       (clk),
    .reset     (reset),
    .start     (int_start),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .done      (int_done),
    .rdata     (int_rdata)
  );

  sram_ctrl u_ext_ram (
    .clk       (clk),
    .reset     (reset),
    .start     (ext_start),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .done      (ext_done),
    .rdata     (ext_rdata),
    .prg_addr  (prg_addr),
    .prg_ce    (prg_ce),
    .prg_oe    (prg_oe),
    .prg_we    (prg_we),
    .prg_data  (prg_data)
  );

  bus_return u_return (
    .clk        (clk),
    .reset      (reset),
    .int_done   (int_done),
    .int_rdata  (int_rdata),
    .ext_done   (ext_done),
    .ext_rdata  (ext_rdata),
    .none_start (none_start),
    .req_write  (req_write),
    .read_dn    (read_dn),
    .write_dn   (write_dn),
    .rdata      (rdata),
    .busy_clear (busy_clear)
  );

endmodule

// File: bench/sram_model.sv
`timescale 1ns/100ps

module sram_model (
  input  mem_bus_pkg::sram_addr_t prg_addr,
  input  logic                    prg_ce,   // strobes all active low
  input  logic                    prg_oe,
  input  logic                    prg_we,
  inout  wire mem_bus_pkg::data_t prg_data
);
  import mem_bus_pkg::*;

  data_t mem [sram_addr_t]; // sparse storage
  data_t read_word;
  logic  out_en;

  // unwritten words read as zero
  function automatic data_t peek_word(input sram_addr_t a);
    return mem.exists(a) ? mem[a] : '0;
  endfunction

  // word lands when we goes back high
  always @(posedge prg_we) begin
    if (!prg_ce) begin
      mem[prg_addr] = prg_data;
    end
  end

  // async read path
  always @(prg_addr or prg_ce or prg_oe or prg_we) begin
    read_word = peek_word(prg_addr);
  end

  assign out_en   = !prg_ce && !prg_oe && prg_we; // drive only on a clean read
  assign prg_data = out_en ? read_word : 'z;

endmodule

// File: bench/mem_bus_tb.sv
`timescale 1ns/100ps

module mem_bus_tb;
  import mem_bus_pkg::*;

  localparam int N_DIRECTED  = 38;  // fixed accesses before the random mix
  localparam int N_RANDOM    = 400;
  localparam int N_ACCESSES  = N_DIRECTED + N_RANDOM;
  localparam int CYCLE_LIMIT = 10 * N_ACCESSES + 10; // slack for reset and idle checks
  localparam int DRIVE_DELAY = 1;   // ns past the rising edge

  logic       clk;
  logic       reset;
  logic       read_q;
  logic       write_q;
  addr_t      addr;
  data_t      wdata;
  logic       read_dn;
  logic       write_dn;
  data_t      rdata;
  sram_addr_t prg_addr;
  logic       prg_ce;
  logic       prg_oe;
  logic       prg_we;
  wire data_t prg_data;       // shared tristate bus

  data_t  int_model [INT_MEM_WORDS]; // internal ram image
  data_t  ext_model [addr_t];        // external words by bus address
  addr_t  ext_pool [8];              // low end 0..3 and high end 4..7
  data_t  last_rdata;                // rdata must hold this between reads
  integer seed;
  int     cycle_count = 0;

  mem_bus_top DUT (.*);

  sram_model u_sram (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // hung run guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles, a done strobe never arrived", cycle_count);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected, $time);
      $display("TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // address map as the bus defines it
  function automatic region_t classify_addr(input addr_t a);
    if (a < addr_t'(INT_MEM_WORDS)) return REGION_INT;
    if (a < addr_t'(EXT_MEM_END)) return REGION_EXT;
    return REGION_NONE;
  endfunction

  function automatic data_t model_read(input addr_t a);
    case (classify_addr(a))
      REGION_INT: return int_model[a[INT_ADDR_WIDTH-1:0]];
      REGION_EXT: return ext_model.exists(a) ? ext_model[a] : '0;
      default:    return '0; // unmapped reads zero
    endcase
  endfunction

  task automatic model_write(input addr_t a, input data_t d);
    case (classify_addr(a))
      REGION_INT: int_model[a[INT_ADDR_WIDTH-1:0]] = d;
      REGION_EXT: ext_model[a] = d;
      default:    ; // unmapped write is dropped
    endcase
  endtask

  // one request from the drive point to done and then one idle cycle
  task automatic run_access(input logic wr, input addr_t a, input data_t d);
    region_t    region;
    sram_addr_t sa;
    data_t      expected;
    int         edges;
    region   = classify_addr(a);
    sa       = sram_addr_t'(a - addr_t'(INT_MEM_WORDS));
    expected = model_read(a);
    read_q   = !wr;
    write_q  = wr;
    addr     = a;
    wdata    = d;
    edges    = 0;
    do begin
      @(posedge clk);
      #DRIVE_DELAY;
      edges++;
      if (region == REGION_EXT && !prg_ce) begin
        check_value("prg_addr", 32'(prg_addr), 32'(sa)); // offset by the int region
      end else if (region != REGION_EXT) begin
        check_value("prg_ce", 32'(prg_ce), 32'd1); // sram must stay idle
      end
    end while (!(read_dn || write_dn));
    check_value("read_dn", 32'(read_dn), 32'(!wr));
    check_value("write_dn", 32'(write_dn), 32'(wr));
    // first edge is the sampling edge
    check_value("done latency", 32'(edges - 1), (region == REGION_EXT) ? 32'd5 : 32'd3);
    if (!wr) begin
      check_value("rdata", rdata, expected);
      last_rdata = expected;
    end else begin
      model_write(a, d);
      if (region == REGION_EXT) begin
        check_value("sram_model word", u_sram.peek_word(sa), d);
      end
    end
    read_q  = 1'b0;
    write_q = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    check_value("read_dn idle", 32'(read_dn), 32'd0); // strobe one cycle wide
    check_value("write_dn idle", 32'(write_dn), 32'd0);
    check_value("rdata held", rdata, last_rdata);
  endtask

  initial begin
    logic [31:0] rnd;
    logic        wr;
    addr_t       a;
    data_t       d;
    seed         = 87426;
    reset        = 1'b1;
    read_q       = 1'b0;
    write_q      = 1'b0;
    addr         = '0;
    wdata        = '0;
    last_rdata   = '0;
    int_model    = '{default: '0};
    $readmemh(MEM_INIT_FILE, int_model);
    ext_pool = '{addr_t'(INT_MEM_WORDS), addr_t'(INT_MEM_WORDS + 1),
                 addr_t'(INT_MEM_WORDS + 2), addr_t'(INT_MEM_WORDS + 3),
                 addr_t'(EXT_MEM_END - 4), addr_t'(EXT_MEM_END - 3),
                 addr_t'(EXT_MEM_END - 2), addr_t'(EXT_MEM_END - 1)};
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    // quiet bus out of reset
    repeat (2) begin
      check_value("read_dn", 32'(read_dn), 32'd0);
      check_value("write_dn", 32'(write_dn), 32'd0);
      check_value("rdata", rdata, 32'd0);
      check_value("prg_ce", 32'(prg_ce), 32'd1);
      check_value("prg_oe", 32'(prg_oe), 32'd1);
      check_value("prg_we", 32'(prg_we), 32'd1);
      @(posedge clk);
      #DRIVE_DELAY;
    end
    // internal startup image then write and read back
    for (int i = 0; i < 16; i++) run_access(1'b0, addr_t'(i), '0);
    run_access(1'b0, addr_t'(INT_MEM_WORDS - 1), '0);
    run_access(1'b1, addr_t'(3), 32'hcafe_0003);
    run_access(1'b1, addr_t'(100), 32'h1234_5678);
    run_access(1'b1, addr_t'(INT_MEM_WORDS - 1), 32'hdead_beef);
    run_access(1'b0, addr_t'(3), '0);
    run_access(1'b0, addr_t'(100), '0);
    run_access(1'b0, addr_t'(INT_MEM_WORDS - 1), '0);
    // external at both ends of the window
    run_access(1'b1, ext_pool[0], 32'h5a5a_0001);
    run_access(1'b1, ext_pool[1], 32'ha5a5_0002);
    run_access(1'b1, ext_pool[7], 32'h0f0f_0003);
    run_access(1'b1, ext_pool[6], 32'hf0f0_0004);
    run_access(1'b0, ext_pool[0], '0);
    run_access(1'b0, ext_pool[1], '0);
    run_access(1'b0, ext_pool[7], '0);
    run_access(1'b0, ext_pool[6], '0);
    run_access(1'b0, ext_pool[2], '0); // never written
    // unmapped addresses alias sram word 0 and int word 3 on their low bits
    run_access(1'b1, addr_t'(EXT_MEM_END + INT_MEM_WORDS), 32'hbad0_0001);
    run_access(1'b1, 32'hffff_ff03, 32'hbad0_0002);
    run_access(1'b0, addr_t'(EXT_MEM_END + INT_MEM_WORDS), '0);
    run_access(1'b0, 32'hffff_ff03, '0);
    run_access(1'b0, ext_pool[0], '0); // still the earlier write
    run_access(1'b0, addr_t'(3), '0);
    // random mix over all regions
    repeat (N_RANDOM) begin
      rnd = $random(seed);
      wr  = rnd[2];
      d   = $random(seed);
      case (rnd[1:0])
        2'd0:    a = $random(seed) % 32'd200;
        2'd1:    a = ext_pool[{1'b0, d[1:0]}];
        2'd2:    a = ext_pool[{1'b1, d[3:2]}];
        default: a = addr_t'(EXT_MEM_END) + ($random(seed) & 32'h000f_ffff);
      endcase
      run_access(wr, a, d);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: mem.hex
// one 32-bit hex word per line, internal ram words 0x00 to 0x0f
// words 0x10 and up start at zero
0badc0de
11110001
22220002
33330003
44440004
55550005
66660006
77770007
88880008
99990009
aaaa000a
bbbb000b
cccc000c
dddd000d
eeee000e
ffff000f

// File: verilog.f
rtl/mem_bus_pkg.sv
rtl/region_decode.sv
rtl/startup_ram.sv
rtl/sram_ctrl.sv
rtl/bus_return.sv
rtl/mem_bus_top.sv
bench/sram_model.sv
bench/mem_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_bus_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TESTS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
